// File: design/cp0_pkg.sv
package cp0_pkg;

    typedef logic [2:0] cp0_addr_t;   // Wishbone word address

    localparam cp0_addr_t CP0_INDEX    = 3'd0;
    localparam cp0_addr_t CP0_ENTRYHI  = 3'd1;
    localparam cp0_addr_t CP0_ENTRYLO0 = 3'd2;
    localparam cp0_addr_t CP0_ENTRYLO1 = 3'd3;
    localparam cp0_addr_t CP0_CMD      = 3'd4;

    typedef logic [1:0] cp0_cmd_t;

    localparam cp0_cmd_t CMD_TLBP  = 2'd1;
    localparam cp0_cmd_t CMD_TLBR  = 2'd2;
    localparam cp0_cmd_t CMD_TLBWI = 2'd3;

    typedef logic [2:0] exc_code_t;

    localparam exc_code_t EXC_NONE      = 3'd0;
    localparam exc_code_t EXC_REFILL_L  = 3'd1;
    localparam exc_code_t EXC_REFILL_S  = 3'd2;
    localparam exc_code_t EXC_INVALID_L = 3'd3;
    localparam exc_code_t EXC_INVALID_S = 3'd4;
    localparam exc_code_t EXC_MODIFY    = 3'd5;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        ACK
    } cp0_state_t;

endpackage

// File: design/cp0_tlb_regs.sv
module cp0_tlb_regs import mmu_pkg::*, cp0_pkg::*; #(
    parameter  int TLBNUM = 16,
    localparam int IDX_W  = $clog2(TLBNUM)
) (
    input  logic             clk,
    input  logic             reset,

    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  cp0_addr_t        wb_adr,
    input  logic [31:0]      wb_dat_w,
    output logic [31:0]      wb_dat_r,
    output logic             wb_ack,

    output logic             tlbp_active,
    output vpn2_t            tlbp_vpn2,
    output asid_t            search_asid,
    input  logic             s_hit,
    input  logic [IDX_W-1:0] s_index,

    output logic             we,
    output logic [IDX_W-1:0] w_index,
    output vpn2_t            w_vpn2,
    output asid_t            w_asid,
    output logic             w_g,
    output pfn_t             w_pfn0,
    output cattr_t           w_c0,
    output logic             w_d0,
    output logic             w_v0,
    output pfn_t             w_pfn1,
    output cattr_t           w_c1,
    output logic             w_d1,
    output logic             w_v1,

    output logic [IDX_W-1:0] r_index,
    input  vpn2_t            r_vpn2,
    input  asid_t            r_asid,
    input  logic             r_g,
    input  pfn_t             r_pfn0,
    input  cattr_t           r_c0,
    input  logic             r_d0,
    input  logic             r_v0,
    input  pfn_t             r_pfn1,
    input  cattr_t           r_c1,
    input  logic             r_d1,
    input  logic             r_v1
);

    cp0_state_t       state;
    cp0_cmd_t         cmd_q;
    logic             index_p;
    logic [IDX_W-1:0] index_q;
    vpn2_t            ehi_vpn2;
    asid_t            ehi_asid;
    logic [25:0]      lo0_q;   // {pfn, c, d, v, g}
    logic [25:0]      lo1_q;
    logic             bus_wr;
    logic             exec_tlbr;

    assign bus_wr    = state == IDLE && wb_cyc && wb_stb && wb_we;
    assign exec_tlbr = state == EXEC && cmd_q == CMD_TLBR;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            cmd_q <= '0;
        end else begin
            case (state)
                IDLE: if (wb_cyc && wb_stb) begin
                    if (wb_we && wb_adr == CP0_CMD) begin
                        cmd_q <= cp0_cmd_t'(wb_dat_w[1:0]);
                        state <= EXEC;
                    end else begin
                        state <= ACK;
                    end
                end
                EXEC:    state <= ACK;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            index_p  <= 1'b0;
            index_q  <= '0;
            ehi_vpn2 <= '0;
            ehi_asid <= '0;
            lo0_q    <= '0;
            lo1_q    <= '0;
        end else if (bus_wr) begin
            case (wb_adr)
                CP0_INDEX: begin
                    index_p <= wb_dat_w[31];
                    index_q <= wb_dat_w[IDX_W-1:0];
                end
                CP0_ENTRYHI: begin
                    ehi_vpn2 <= wb_dat_w[31:13];
                    ehi_asid <= wb_dat_w[7:0];
                end
                CP0_ENTRYLO0: lo0_q <= wb_dat_w[25:0];
                CP0_ENTRYLO1: lo1_q <= wb_dat_w[25:0];
                default: ;
            endcase
        end else if (tlbp_active) begin
            index_p <= ~s_hit;
            if (s_hit) index_q <= s_index;   // Index kept on a miss
        end else if (exec_tlbr) begin
            ehi_vpn2 <= r_vpn2;
            ehi_asid <= r_asid;
            lo0_q    <= {r_pfn0, r_c0, r_d0, r_v0, r_g};
            lo1_q    <= {r_pfn1, r_c1, r_d1, r_v1, r_g};
        end
    end

    always_comb begin
        case (wb_adr)
            CP0_INDEX:    wb_dat_r = {index_p, {(31 - IDX_W){1'b0}}, index_q};
            CP0_ENTRYHI:  wb_dat_r = {ehi_vpn2, 5'b0, ehi_asid};
            CP0_ENTRYLO0: wb_dat_r = {6'b0, lo0_q};
            CP0_ENTRYLO1: wb_dat_r = {6'b0, lo1_q};
            default:      wb_dat_r = '0;
        endcase
    end

    assign wb_ack      = state == ACK;
    assign tlbp_active = state == EXEC && cmd_q == CMD_TLBP;
    assign tlbp_vpn2   = ehi_vpn2;
    assign search_asid = ehi_asid;

    assign we      = state == EXEC && cmd_q == CMD_TLBWI;
    assign w_index = index_q;
    assign w_vpn2  = ehi_vpn2;
    assign w_asid  = ehi_asid;
    assign w_g     = lo0_q[0] & lo1_q[0];   // Global only if both halves say so
    assign w_pfn0  = lo0_q[25:6];
    assign w_c0    = lo0_q[5:3];
    assign w_d0    = lo0_q[2];
    assign w_v0    = lo0_q[1];
    assign w_pfn1  = lo1_q[25:6];
    assign w_c1    = lo1_q[5:3];
    assign w_d1    = lo1_q[2];
    assign w_v1    = lo1_q[1];
    assign r_index = index_q;

endmodule

// File: design/mmu_pkg.sv
package mmu_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [18:0] vpn2_t;   // vaddr[31:13], one even/odd page pair
    typedef logic [19:0] pfn_t;
    typedef logic [7:0]  asid_t;
    typedef logic [2:0]  cattr_t;

    // kseg0 and kseg1 both map onto the low 512 MB
    localparam paddr_t KSEG_MASK = 32'h1fff_ffff;

    // vaddr[31:30] pattern shared by kseg0 and kseg1
    localparam logic [1:0] KSEG_TOP = 2'b10;

endpackage

// File: design/mmu_top.sv
module mmu_top import mmu_pkg::*, cp0_pkg::*; #(
    parameter  int TLBNUM = 16,
    localparam int IDX_W  = $clog2(TLBNUM)
) (
    input  logic        clk,
    input  logic        reset,

    input  logic        req_valid,
    input  vaddr_t      req_vaddr,
    input  logic        req_store,
    output logic        req_ready,
    output logic        resp_valid,
    output paddr_t      resp_paddr,
    output exc_code_t   resp_exc,

    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  cp0_addr_t   wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    // Translation pipeline
    logic             tlbp_active;
    vpn2_t            tlbp_vpn2;
    logic             s1_valid;
    vaddr_t           s1_vaddr;
    logic             s1_store;
    logic             s1_direct;

    // TLB search port
    vpn2_t            search_vpn2;
    logic             search_odd;
    asid_t            search_asid;
    logic             s_hit;
    logic [IDX_W-1:0] s_index;
    pfn_t             s_pfn;
    logic             s_d;
    logic             s_v;

    // TLB write and read ports
    logic             we;
    logic [IDX_W-1:0] w_index;
    vpn2_t            w_vpn2;
    asid_t            w_asid;
    logic             w_g;
    pfn_t             w_pfn0;
    cattr_t           w_c0;
    logic             w_d0;
    logic             w_v0;
    pfn_t             w_pfn1;
    cattr_t           w_c1;
    logic             w_d1;
    logic             w_v1;
    logic [IDX_W-1:0] r_index;
    vpn2_t            r_vpn2;
    asid_t            r_asid;
    logic             r_g;
    pfn_t             r_pfn0;
    cattr_t           r_c0;
    logic             r_d0;
    logic             r_v0;
    pfn_t             r_pfn1;
    cattr_t           r_c1;
    logic             r_d1;
    logic             r_v1;

    xlat_fetch_stage fetch_i (.*);

    // Cache attribute of a search is not consumed here
    tlb_array #(
        .TLBNUM (TLBNUM)
    ) tlb_i (
        .s_c (),
        .*
    );

    xlat_resolve_stage resolve_i (.*);

    cp0_tlb_regs #(
        .TLBNUM (TLBNUM)
    ) cp0_i (.*);

endmodule

// File: design/tlb_array.sv
module tlb_array import mmu_pkg::*; #(
    parameter  int TLBNUM = 16,
    localparam int IDX_W  = $clog2(TLBNUM)
) (
    input  logic             clk,
    input  logic             reset,

    input  vpn2_t            search_vpn2,
    input  logic             search_odd,
    input  asid_t            search_asid,
    output logic             s_hit,
    output logic [IDX_W-1:0] s_index,
    output pfn_t             s_pfn,
    output cattr_t           s_c,
    output logic             s_d,
    output logic             s_v,

    input  logic             we,
    input  logic [IDX_W-1:0] w_index,
    input  vpn2_t            w_vpn2,
    input  asid_t            w_asid,
    input  logic             w_g,
    input  pfn_t             w_pfn0,
    input  cattr_t           w_c0,
    input  logic             w_d0,
    input  logic             w_v0,
    input  pfn_t             w_pfn1,
    input  cattr_t           w_c1,
    input  logic             w_d1,
    input  logic             w_v1,

    input  logic [IDX_W-1:0] r_index,
    output vpn2_t            r_vpn2,
    output asid_t            r_asid,
    output logic             r_g,
    output pfn_t             r_pfn0,
    output cattr_t           r_c0,
    output logic             r_d0,
    output logic             r_v0,
    output pfn_t             r_pfn1,
    output cattr_t           r_c1,
    output logic             r_d1,
    output logic             r_v1
);

    vpn2_t            tlb_vpn2 [TLBNUM];
    asid_t            tlb_asid [TLBNUM];
    logic             tlb_g    [TLBNUM];
    pfn_t   [1:0]     tlb_pfn  [TLBNUM];   // Index 1 is the odd page
    cattr_t [1:0]     tlb_c    [TLBNUM];
    logic   [1:0]     tlb_d    [TLBNUM];
    logic   [1:0]     tlb_v    [TLBNUM];
    logic [TLBNUM-1:0] match;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TLBNUM; i++) begin
                tlb_vpn2[i] <= '0;
                tlb_asid[i] <= '0;
                tlb_g[i]    <= 1'b0;
                tlb_d[i]    <= 2'b00;
                tlb_v[i]    <= 2'b00;
            end
        end else if (we) begin
            tlb_vpn2[w_index] <= w_vpn2;
            tlb_asid[w_index] <= w_asid;
            tlb_g[w_index]    <= w_g;
            tlb_pfn[w_index]  <= {w_pfn1, w_pfn0};
            tlb_c[w_index]    <= {w_c1, w_c0};
            tlb_d[w_index]    <= {w_d1, w_d0};
            tlb_v[w_index]    <= {w_v1, w_v0};
        end
    end

    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            match[i] = (tlb_vpn2[i] == search_vpn2) &&
                       (tlb_g[i] || tlb_asid[i] == search_asid);
        end
    end

    // Walk downwards so the lowest matching entry is kept
    always_comb begin
        s_index = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (match[i]) s_index = IDX_W'(i);
        end
    end

    assign s_hit  = |match;
    assign s_pfn  = tlb_pfn[s_index][search_odd];
    assign s_c    = tlb_c[s_index][search_odd];
    assign s_d    = tlb_d[s_index][search_odd];
    assign s_v    = tlb_v[s_index][search_odd];

    assign r_vpn2 = tlb_vpn2[r_index];
    assign r_asid = tlb_asid[r_index];
    assign r_g    = tlb_g[r_index];
    assign r_pfn0 = tlb_pfn[r_index][0];
    assign r_c0   = tlb_c[r_index][0];
    assign r_d0   = tlb_d[r_index][0];
    assign r_v0   = tlb_v[r_index][0];
    assign r_pfn1 = tlb_pfn[r_index][1];
    assign r_c1   = tlb_c[r_index][1];
    assign r_d1   = tlb_d[r_index][1];
    assign r_v1   = tlb_v[r_index][1];

endmodule

// File: design/xlat_fetch_stage.sv
module xlat_fetch_stage import mmu_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   req_valid,
    input  vaddr_t req_vaddr,
    input  logic   req_store,
    output logic   req_ready,
    input  logic   tlbp_active,
    input  vpn2_t  tlbp_vpn2,
    output logic   s1_valid,
    output vaddr_t s1_vaddr,
    output logic   s1_store,
    output logic   s1_direct,
    output vpn2_t  search_vpn2,
    output logic   search_odd
);

    logic valid_q;

    assign req_ready = ~tlbp_active;   // TLBP owns the search port

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (req_ready) begin
            valid_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            s1_vaddr  <= req_vaddr;
            s1_store  <= req_store;
            s1_direct <= req_vaddr[31:30] == KSEG_TOP;
        end
    end

    // Held item is not passed on while TLBP searches
    assign s1_valid    = valid_q & ~tlbp_active;
    assign search_vpn2 = tlbp_active ? tlbp_vpn2 : s1_vaddr[31:13];
    assign search_odd  = s1_vaddr[12];

endmodule

// File: design/xlat_resolve_stage.sv
module xlat_resolve_stage import mmu_pkg::*, cp0_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      s1_valid,
    input  vaddr_t    s1_vaddr,
    input  logic      s1_store,
    input  logic      s1_direct,
    input  logic      s_hit,
    input  pfn_t      s_pfn,
    input  logic      s_d,
    input  logic      s_v,
    output logic      resp_valid,
    output paddr_t    resp_paddr,
    output exc_code_t resp_exc
);

    paddr_t    paddr_d;
    exc_code_t exc_d;

    always_comb begin
        paddr_d = '0;
        exc_d   = EXC_NONE;
        if (s1_direct) begin
            paddr_d = s1_vaddr & KSEG_MASK;
        end else if (!s_hit) begin
            exc_d = s1_store ? EXC_REFILL_S : EXC_REFILL_L;
        end else if (!s_v) begin
            exc_d = s1_store ? EXC_INVALID_S : EXC_INVALID_L;
        end else if (s1_store && !s_d) begin
            exc_d = EXC_MODIFY;   // Store to a clean page
        end else begin
            paddr_d = {s_pfn, s1_vaddr[11:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            resp_paddr <= paddr_d;
            resp_exc   <= exc_d;
        end
    end

endmodule

// File: filelist.f
design/mmu_pkg.sv
design/cp0_pkg.sv
design/tlb_array.sv
design/cp0_tlb_regs.sv
design/xlat_fetch_stage.sv
design/xlat_resolve_stage.sv
design/mmu_top.sv
verification/mmu_chk.sv
verification/mmu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the MMU testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module mmu_tb -f filelist.f -o mmu_sim \
    && ./obj_dir/mmu_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verification/mmu_chk.sv
module mmu_chk (
    input logic clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic req_valid,
    input logic req_ready,
    input logic resp_valid,
    input logic tlbp_active
);

    ack_needs_strobe: assert property (
        @(posedge clk) disable iff (reset) wb_ack |-> wb_cyc && wb_stb
    ) else $error("wb_ack raised without an active bus cycle");

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (reset) wb_ack |=> !wb_ack
    ) else $error("wb_ack held high for two cycles");

    // A TLBP in the cycle after the transfer delays the response
    resp_latency: assert property (
        @(posedge clk) disable iff (reset)
        (req_valid && req_ready) ##1 !tlbp_active |=> resp_valid
    ) else $error("translation response missing two cycles after transfer");

    quiet_in_reset: assert property (
        @(posedge clk) $past(reset) && reset |-> !resp_valid && !wb_ack
    ) else $error("resp_valid or wb_ack high during reset");

endmodule

// File: verification/mmu_tb.sv
module mmu_tb import mmu_pkg::*, cp0_pkg::*; ();

    localparam int TLBNUM = 16;

    logic        clk;
    logic        reset;
    logic        req_valid;
    vaddr_t      req_vaddr;
    logic        req_store;
    logic        req_ready;
    logic        resp_valid;
    paddr_t      resp_paddr;
    exc_code_t   resp_exc;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    cp0_addr_t   wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    // Reference TLB contents as written through CP0
    vpn2_t  m_vpn2 [TLBNUM];
    asid_t  m_asid [TLBNUM];
    logic   m_g    [TLBNUM];
    pfn_t   m_pfn  [TLBNUM][2];
    cattr_t m_c    [TLBNUM][2];
    logic   m_d    [TLBNUM][2];
    logic   m_v    [TLBNUM][2];
    asid_t  cur_asid;
    int     idx_model;
    logic   p_model;

    logic [34:0] exp_q[$];   // {paddr, exc} per accepted request
    logic [34:0] exp_head;
    int          cycles;

    mmu_top #(.TLBNUM(TLBNUM)) mmu_top_i (.*);

    bind mmu_top mmu_chk chk_i (
        .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
        .req_valid(req_valid), .req_ready(req_ready), .resp_valid(resp_valid),
        .tlbp_active(tlbp_active)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(string what, logic [34:0] got, logic [34:0] exp);
        assert (got === exp) else
            report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                     $time, what, got, exp));
    endtask

    function automatic int find_entry(vpn2_t vpn2, asid_t asid);
        int hit_i;
        hit_i = -1;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (m_vpn2[i] == vpn2 && (m_g[i] || m_asid[i] == asid)) hit_i = i;
        end
        return hit_i;
    endfunction

    function automatic logic [34:0] expect_xlat(vaddr_t va, logic st);
        int   hit_i;
        logic odd;
        odd = va[12];
        if (va[31:30] == 2'b10) return {3'b000, va[28:0], EXC_NONE};   // kseg0/kseg1
        hit_i = find_entry(va[31:13], cur_asid);
        if (hit_i < 0) return {32'h0, st ? EXC_REFILL_S : EXC_REFILL_L};
        if (!m_v[hit_i][odd]) return {32'h0, st ? EXC_INVALID_S : EXC_INVALID_L};
        if (st && !m_d[hit_i][odd]) return {32'h0, EXC_MODIFY};
        return {m_pfn[hit_i][odd], va[11:0], EXC_NONE};
    endfunction

    function automatic logic [31:0] make_lo(pfn_t pfn, cattr_t c, logic d, logic v, logic g);
        return {6'b0, pfn, c, d, v, g};
    endfunction

    task automatic wb_write(cp0_addr_t adr, logic [31:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        do @(negedge clk); while (!wb_ack);
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_check(cp0_addr_t adr, logic [31:0] exp, string what);
        logic [31:0] data;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do @(negedge clk); while (!wb_ack);
        data = wb_dat_r;
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        check_value(what, {3'b0, data}, {3'b0, exp});
    endtask

    task automatic set_entryhi(vpn2_t vpn2, asid_t asid);
        wb_write(CP0_ENTRYHI, {vpn2, 5'b0, asid});
        cur_asid = asid;
    endtask

    task automatic write_entry(int idx, vpn2_t vpn2, asid_t asid, logic [31:0] lo0,
                               logic [31:0] lo1);
        wb_write(CP0_INDEX, 32'(idx));
        set_entryhi(vpn2, asid);
        wb_write(CP0_ENTRYLO0, lo0);
        wb_write(CP0_ENTRYLO1, lo1);
        wb_write(CP0_CMD, 32'(CMD_TLBWI));
        idx_model    = idx;
        p_model      = 1'b0;
        m_vpn2[idx]  = vpn2;
        m_asid[idx]  = asid;
        m_g[idx]     = lo0[0] & lo1[0];   // Entry is global only if both halves are
        m_pfn[idx][0] = lo0[25:6];
        m_c[idx][0]   = lo0[5:3];
        m_d[idx][0]   = lo0[2];
        m_v[idx][0]   = lo0[1];
        m_pfn[idx][1] = lo1[25:6];
        m_c[idx][1]   = lo1[5:3];
        m_d[idx][1]   = lo1[2];
        m_v[idx][1]   = lo1[1];
    endtask

    task automatic read_entry_check(int idx);
        wb_write(CP0_INDEX, 32'(idx));
        wb_write(CP0_CMD, 32'(CMD_TLBR));
        cur_asid = m_asid[idx];
        read_check(CP0_ENTRYHI, {m_vpn2[idx], 5'b0, m_asid[idx]}, "TLBR EntryHi");
        read_check(CP0_ENTRYLO0, make_lo(m_pfn[idx][0], m_c[idx][0], m_d[idx][0],
                   m_v[idx][0], m_g[idx]), "TLBR EntryLo0");
        read_check(CP0_ENTRYLO1, make_lo(m_pfn[idx][1], m_c[idx][1], m_d[idx][1],
                   m_v[idx][1], m_g[idx]), "TLBR EntryLo1");
    endtask

    task automatic probe_check(vpn2_t vpn2);
        int hit_i;
        wb_write(CP0_ENTRYHI, {vpn2, 5'b0, cur_asid});   // ASID kept for in-flight requests
        wb_write(CP0_CMD, 32'(CMD_TLBP));
        hit_i   = find_entry(vpn2, cur_asid);
        p_model = hit_i < 0;
        if (hit_i >= 0) idx_model = hit_i;
        read_check(CP0_INDEX, {p_model, 27'b0, 4'(idx_model)}, "TLBP Index");
    endtask

    task automatic send_req(vaddr_t va, logic st);
        req_valid = 1'b1;
        req_vaddr = va;
        req_store = st;
        do @(negedge clk); while (!req_ready);
        @(posedge clk);
        #1;
    endtask

    task automatic drain;
        req_valid = 1'b0;
        do @(negedge clk); while (exp_q.size() != 0);
        @(posedge clk);
        #1;
    endtask

    // Responses are checked and requests recorded where both are stable
    always @(negedge clk) begin
        if (!reset) begin
            if (resp_valid) begin
                if (exp_q.size() == 0) report_failure("response arrived with no request pending");
                exp_head = exp_q.pop_front();
                check_value("translation", {resp_paddr, resp_exc}, exp_head);
            end
            if (req_valid && req_ready) exp_q.push_back(expect_xlat(req_vaddr, req_store));
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= 4000) report_failure("timeout: the run went past 4000 cycles");
    end

    initial begin
        void'($urandom(32'hee4a_e569));
        cycles    = 0;
        reset     = 1'b1;
        req_valid = 1'b0;
        req_vaddr = '0;
        req_store = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        cur_asid  = '0;
        idx_model = 0;
        p_model   = 1'b0;
        for (int i = 0; i < TLBNUM; i++) begin   // Entries come out of reset cleared
            m_vpn2[i] = '0;
            m_asid[i] = '0;
            m_g[i]    = 1'b0;
            for (int j = 0; j < 2; j++) begin
                m_pfn[i][j] = '0;
                m_c[i][j]   = '0;
                m_d[i][j]   = 1'b0;
                m_v[i][j]   = 1'b0;
            end
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        wb_write(CP0_INDEX, 32'h8000_00ff);
        read_check(CP0_INDEX, 32'h8000_000f, "Index");
        wb_write(CP0_ENTRYHI, 32'hffff_ffff);
        read_check(CP0_ENTRYHI, 32'hffff_e0ff, "EntryHi");
        wb_write(CP0_ENTRYLO0, 32'hffff_ffff);
        read_check(CP0_ENTRYLO0, 32'h03ff_ffff, "EntryLo0");
        wb_write(CP0_ENTRYLO1, 32'hffff_fffe);
        read_check(CP0_ENTRYLO1, 32'h03ff_fffe, "EntryLo1");

        for (int k = 0; k < 8; k++) begin
            int idx;
            idx = $urandom % TLBNUM;
            write_entry(idx, vpn2_t'($urandom), asid_t'($urandom), $urandom, $urandom);
            read_entry_check(idx);
        end

        write_entry(5, 19'h00123, 8'h11, make_lo(20'h0abcd, 3'd3, 1'b1, 1'b1, 1'b0),
                    make_lo(20'h0beef, 3'd2, 1'b0, 1'b1, 1'b0));
        write_entry(9, 19'h00456, 8'h22, make_lo(20'h12345, 3'd3, 1'b1, 1'b1, 1'b1),
                    make_lo(20'h6789a, 3'd3, 1'b1, 1'b1, 1'b1));
        write_entry(3, 19'h00789, 8'h11, make_lo(20'h11111, 3'd0, 1'b1, 1'b0, 1'b0),
                    make_lo(20'h22222, 3'd0, 1'b1, 1'b1, 1'b0));
        write_entry(7, 19'h40091, 8'h11, make_lo(20'h33333, 3'd2, 1'b1, 1'b1, 1'b1),
                    make_lo(20'h44444, 3'd2, 1'b1, 1'b1, 1'b1));   // Global entry over kseg0
        set_entryhi(19'h00123, 8'h11);

        fork
            begin
                probe_check(19'h00123);
                probe_check(19'h7abcd);   // Absent page pair
                probe_check(19'h00456);
            end
            begin
                for (int k = 0; k < 12; k++) send_req({19'h00123, 1'(k), 12'(k * 52)}, k[1]);
                drain();
            end
        join

        send_req({19'h00123, 1'b0, 12'h345}, 1'b0);
        send_req({19'h00123, 1'b0, 12'h346}, 1'b1);
        send_req({19'h00123, 1'b1, 12'hfff}, 1'b0);
        send_req({19'h00456, 1'b0, 12'h010}, 1'b0);
        send_req({19'h00456, 1'b1, 12'h020}, 1'b1);
        send_req({19'h00789, 1'b0, 12'h030}, 1'b0);
        send_req({19'h00789, 1'b0, 12'h031}, 1'b1);
        send_req({19'h00789, 1'b1, 12'h032}, 1'b1);
        send_req({19'h00123, 1'b1, 12'h040}, 1'b1);
        send_req({19'h55555, 1'b0, 12'h050}, 1'b0);
        send_req({19'h55555, 1'b1, 12'h051}, 1'b1);
        drain();

        set_entryhi(19'h00123, 8'h77);
        send_req({19'h00456, 1'b1, 12'h0aa}, 1'b0);
        send_req({19'h00123, 1'b0, 12'h0bb}, 1'b0);
        send_req(32'h8012_3456, 1'b0);
        send_req(32'h8012_3457, 1'b1);
        send_req(32'ha012_3456, 1'b0);
        send_req(32'hbfff_fffc, 1'b1);
        drain();

        $display("All tests passed");
        $finish;
    end

endmodule
